/* flist.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/spi_master.sv
rtl/io_regs.sv
rtl/board_top.sv
tests/board_top_properties.sv
tests/tb_board_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_board_top -o sim_tb_board_top

out=$(./obj_dir/sim_tb_board_top) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
   exit 0
else
   exit 1
fi

/* tests/tb_board_top.sv */
`timescale 1ns/100ps
`include "soc_defs.svh"

module tb_board_top import soc_pkg::*; ();

   // 11 UART frames near 170 cycles, 8 SPI exchanges near 40, idle window and polling
   localparam int CYCLE_LIMIT = 5000;

   logic      clk;
   logic      SYS_RST_N;
   logic      wr_stb;
   logic      rd_stb;
   reg_addr_t addr;
   reg_data_t wr_data;
   reg_data_t rd_data;
   logic      rd_valid;
   logic      uart_rxd;
   logic      uart_txd;
   logic      spi_miso;
   logic      spi_sck;
   logic      spi_cs_n;
   logic      spi_mosi;

   int        seed = 32'h317c_0704;
   int        errors = 0;
   int        cycles = 0;
   byte_t     slave_reply;       // Byte the SPI slave sends back
   byte_t     slave_tx;          // Slave outgoing shift register
   byte_t     slave_rx;          // Bits taken from spi_mosi
   logic      sck_prev = 1'b0;

   assign uart_rxd = uart_txd;   // Loopback

   board_top dut0 (
      .clk       (clk),
      .SYS_RST_N (SYS_RST_N),
      .wr_stb    (wr_stb),
      .rd_stb    (rd_stb),
      .addr      (addr),
      .wr_data   (wr_data),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .uart_rxd  (uart_rxd),
      .uart_txd  (uart_txd),
      .spi_miso  (spi_miso),
      .spi_sck   (spi_sck),
      .spi_cs_n  (spi_cs_n),
      .spi_mosi  (spi_mosi)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run timed out after %0d cycles without finishing the tests", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////
   // SPI slave model
   ////////////////////

   always @(negedge clk) begin
      if (spi_cs_n) begin
         slave_tx = slave_reply;                  // Reload while deselected
         spi_miso = slave_reply[7];
      end else if (spi_sck && !sck_prev) begin
         slave_rx = {slave_rx[6:0], spi_mosi};    // Rising sck seen
         slave_tx = {slave_tx[6:0], 1'b0};
      end else if (!spi_sck) begin
         spi_miso = slave_tx[7];                  // Next bit while sck low
      end
      sck_prev = spi_sck;
   end

   ////////////////////
   // Register access
   ////////////////////

   task automatic write_reg(input reg_addr_t a, input reg_data_t d);
      @(negedge clk);
      wr_stb  = 1'b1;
      addr    = a;
      wr_data = d;
      @(negedge clk);
      wr_stb  = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t a, output reg_data_t d);
      @(negedge clk);
      rd_stb = 1'b1;
      addr   = a;
      @(negedge clk);
      rd_stb = 1'b0;                              // Response due now
      assert (rd_valid === 1'b1) else begin
         $display("Read of address %0d got no rd_valid one cycle after the strobe", a);
         errors++;
      end
      d = rd_data;
   endtask

   // Poll until one status bit reaches a value
   task automatic wait_status(input logic [2:0] pos, input logic val);
      reg_data_t st;
      read_reg(`REG_STATUS, st);
      while (st[pos] !== val)
         read_reg(`REG_STATUS, st);
   endtask

   task automatic check_byte(input string name, input reg_data_t got, input reg_data_t exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      reg_data_t st;
      reg_data_t got;
      byte_t     tx;
      byte_t     tx2;
      SYS_RST_N   = 1'b0;
      wr_stb      = 1'b0;
      rd_stb      = 1'b0;
      addr        = '0;
      wr_data     = '0;
      spi_miso    = 1'b0;
      slave_reply = '0;
      slave_rx    = '0;
      repeat (5) @(negedge clk);
      SYS_RST_N = 1'b1;
      repeat (3) @(negedge clk);                  // Synchronizer release

      // Reset state
      check_flag("uart_txd", uart_txd, 1'b1);
      check_flag("spi_cs_n", spi_cs_n, 1'b1);
      check_flag("spi_sck", spi_sck, 1'b0);
      read_reg(`REG_STATUS, st);
      check_byte("status", st, 8'h00);

      // UART loopback
      for (int i = 0; i < 8; i++) begin
         tx = byte_t'($random(seed));
         wait_status(`ST_TX_BUSY, 1'b0);
         write_reg(`REG_UART_DATA, tx);
         wait_status(`ST_RX_VALID, 1'b1);
         read_reg(`REG_UART_DATA, got);
         check_byte("uart rx data", got, tx);
         read_reg(`REG_STATUS, st);
         check_flag("ST_RX_VALID", st[`ST_RX_VALID], 1'b0);
      end

      // Second write lands while busy
      wait_status(`ST_TX_BUSY, 1'b0);
      tx  = byte_t'($random(seed));
      tx2 = ~tx;
      write_reg(`REG_UART_DATA, tx);
      write_reg(`REG_UART_DATA, tx2);
      read_reg(`REG_STATUS, st);
      check_flag("ST_TX_BUSY", st[`ST_TX_BUSY], 1'b1);
      wait_status(`ST_RX_VALID, 1'b1);
      read_reg(`REG_UART_DATA, got);
      check_byte("uart rx data", got, tx);
      wait_status(`ST_TX_BUSY, 1'b0);
      repeat (12 * `UART_DIV) @(negedge clk);    // Room for a stray frame
      read_reg(`REG_STATUS, st);
      check_flag("ST_RX_VALID", st[`ST_RX_VALID], 1'b0);

      // SPI exchanges
      for (int i = 0; i < 8; i++) begin
         tx          = byte_t'($random(seed));
         slave_reply = byte_t'($random(seed));
         write_reg(`REG_SPI_DATA, tx);
         wait_status(`ST_SPI_BUSY, 1'b0);
         check_byte("spi_mosi byte", slave_rx, tx);
         read_reg(`REG_SPI_DATA, got);
         check_byte("spi rx data", got, slave_reply);
      end

      // Overrun, newest byte kept
      tx  = byte_t'($random(seed));
      tx2 = byte_t'($random(seed));
      if (tx2 == tx)
         tx2 = ~tx;
      wait_status(`ST_TX_BUSY, 1'b0);
      write_reg(`REG_UART_DATA, tx);
      wait_status(`ST_TX_BUSY, 1'b0);
      write_reg(`REG_UART_DATA, tx2);
      wait_status(`ST_RX_OVERRUN, 1'b1);
      read_reg(`REG_STATUS, st);
      check_flag("ST_RX_VALID", st[`ST_RX_VALID], 1'b1);
      read_reg(`REG_UART_DATA, got);
      check_byte("uart rx data", got, tx2);
      read_reg(`REG_STATUS, st);
      check_flag("ST_RX_VALID", st[`ST_RX_VALID], 1'b0);
      check_flag("ST_RX_OVERRUN", st[`ST_RX_OVERRUN], 1'b0);

      $display("Checks finished with %0d errors", errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* tests/board_top_properties.sv */
`timescale 1ns/100ps

module board_top_properties (
   input logic clk,
   input logic rst_n,
   input logic rd_stb,
   input logic rd_valid,
   input logic tx_busy,
   input logic uart_txd,
   input logic spi_sck,
   input logic spi_cs_n
);

   // Mode 0 clock rests low while deselected
   cs_high_sck_low: assert property (
      @(posedge clk) disable iff (!rst_n) spi_cs_n |-> !spi_sck)
      else $error("spi_sck is high while spi_cs_n is high");

   // Line idles high between frames
   txd_idle_high: assert property (
      @(posedge clk) disable iff (!rst_n) !tx_busy |-> uart_txd)
      else $error("uart_txd is low while the transmitter is idle");

   // Read response one cycle behind the strobe
   rd_valid_delay: assert property (
      @(posedge clk) disable iff (!rst_n) rd_valid == $past(rd_stb))
      else $error("rd_valid does not follow rd_stb by one cycle");

endmodule

bind board_top board_top_properties props0 (
   .clk      (clk),
   .rst_n    (rst_n),
   .rd_stb   (rd_stb),
   .rd_valid (rd_valid),
   .tx_busy  (tx_busy),
   .uart_txd (uart_txd),
   .spi_sck  (spi_sck),
   .spi_cs_n (spi_cs_n)
);

/* rtl/board_top.sv */
`timescale 1ns/100ps

module board_top import soc_pkg::*; (
   input  logic      clk,
   input  logic      SYS_RST_N,    // Board reset, asynchronous
   // Register port
   input  logic      wr_stb,
   input  logic      rd_stb,
   input  reg_addr_t addr,
   input  reg_data_t wr_data,
   output reg_data_t rd_data,
   output logic      rd_valid,
   // Serial pins
   input  logic      uart_rxd,
   output logic      uart_txd,
   input  logic      spi_miso,
   output logic      spi_sck,
   output logic      spi_cs_n,
   output logic      spi_mosi
);

   logic [1:0] rst_sync;     // Release synchronizer
   logic       rst_n;        // Internal reset
   logic       tx_start;
   byte_t      tx_byte;
   logic       tx_busy;
   logic       rx_done;
   byte_t      rx_byte;
   logic       spi_start;
   byte_t      spi_tx_byte;
   logic       spi_busy;
   logic       spi_done;
   byte_t      spi_rx_byte;

   ////////////////////
   // Reset conditioning
   ////////////////////

   // Asserts at once, releases on second edge
   always_ff @(posedge clk or negedge SYS_RST_N) begin
      if (!SYS_RST_N)
         rst_sync <= 2'b00;
      else
         rst_sync <= {rst_sync[0], 1'b1};
   end

   assign rst_n = rst_sync[1];

   ////////////////////
   // Peripherals
   ////////////////////

   io_regs u_io_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_stb      (wr_stb),
      .rd_stb      (rd_stb),
      .addr        (addr),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid),
      .tx_busy     (tx_busy),
      .rx_done     (rx_done),
      .rx_byte     (rx_byte),
      .tx_start    (tx_start),
      .tx_byte     (tx_byte),
      .spi_busy    (spi_busy),
      .spi_done    (spi_done),
      .spi_rx_byte (spi_rx_byte),
      .spi_start   (spi_start),
      .spi_tx_byte (spi_tx_byte)
   );

   uart_tx u_uart_tx (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .tx_busy  (tx_busy),
      .uart_txd (uart_txd)
   );

   uart_rx u_uart_rx (
      .clk      (clk),
      .rst_n    (rst_n),
      .uart_rxd (uart_rxd),
      .rx_done  (rx_done),
      .rx_byte  (rx_byte)
   );

   spi_master u_spi_master (
      .clk         (clk),
      .rst_n       (rst_n),
      .spi_start   (spi_start),
      .spi_tx_byte (spi_tx_byte),
      .spi_miso    (spi_miso),
      .spi_busy    (spi_busy),
      .spi_done    (spi_done),
      .spi_rx_byte (spi_rx_byte),
      .spi_sck     (spi_sck),
      .spi_cs_n    (spi_cs_n),
      .spi_mosi    (spi_mosi)
   );

endmodule

/* rtl/io_regs.sv */
`timescale 1ns/100ps
`include "soc_defs.svh"

module io_regs import soc_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   // Register port
   input  logic      wr_stb,
   input  logic      rd_stb,
   input  reg_addr_t addr,
   input  reg_data_t wr_data,
   output reg_data_t rd_data,
   output logic      rd_valid,
   // UART side
   input  logic      tx_busy,
   input  logic      rx_done,
   input  byte_t     rx_byte,
   output logic      tx_start,
   output byte_t     tx_byte,
   // SPI side
   input  logic      spi_busy,
   input  logic      spi_done,
   input  byte_t     spi_rx_byte,
   output logic      spi_start,
   output byte_t     spi_tx_byte
);

   byte_t     rx_hold;       // Last UART byte
   byte_t     spi_hold;      // Last SPI byte
   logic      rx_valid;
   logic      rx_overrun;
   logic      rd_uart;       // Read of UART data this cycle
   reg_data_t status;
   reg_data_t rd_mux;

   ////////////////////
   // Write decode
   ////////////////////

   // Starts go out in the strobe cycle so units react next edge
   assign tx_start    = wr_stb && (addr == `REG_UART_DATA) && !tx_busy;
   assign spi_start   = wr_stb && (addr == `REG_SPI_DATA) && !spi_busy;
   assign tx_byte     = wr_data;
   assign spi_tx_byte = wr_data;

   assign rd_uart = rd_stb && (addr == `REG_UART_DATA);

   // Receive flags
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end else if (rx_done) begin
         rx_valid <= 1'b1;
         if (rd_uart)
            rx_overrun <= 1'b0;             // Old byte consumed
         else if (rx_valid)
            rx_overrun <= 1'b1;             // Unread byte lost
      end else if (rd_uart) begin
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end
   end

   // Received data holding
   always_ff @(posedge clk) begin
      if (rx_done)
         rx_hold <= rx_byte;                // Newest byte wins
      if (spi_done)
         spi_hold <= spi_rx_byte;
   end

   ////////////////////
   // Read path
   ////////////////////

   always_comb begin
      status                 = '0;
      status[`ST_TX_BUSY]    = tx_busy;
      status[`ST_RX_VALID]   = rx_valid;
      status[`ST_SPI_BUSY]   = spi_busy;
      status[`ST_RX_OVERRUN] = rx_overrun;
   end

   always_comb begin
      case (addr)
         `REG_UART_DATA: rd_mux = rx_hold;
         `REG_STATUS:    rd_mux = status;
         `REG_SPI_DATA:  rd_mux = spi_hold;
         default:        rd_mux = '0;       // Unmapped
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_stb;                // One cycle after strobe
   end

   always_ff @(posedge clk) begin
      if (rd_stb)
         rd_data <= rd_mux;
   end

endmodule

/* rtl/spi_master.sv */
`timescale 1ns/100ps
`include "soc_defs.svh"

module spi_master import soc_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  spi_start,     // Single-cycle pulse
   input  byte_t spi_tx_byte,
   input  logic  spi_miso,
   output logic  spi_busy,
   output logic  spi_done,      // Pulse as CS rises
   output byte_t spi_rx_byte,
   output logic  spi_sck,       // Mode 0, idles low
   output logic  spi_cs_n,
   output logic  spi_mosi
);

   localparam int CNT_W = $clog2(`SPI_HALF + 1);

   spi_state_e       state;
   logic [CNT_W-1:0] half_cnt;    // Cycles within half period
   logic [2:0]       bit_cnt;
   byte_t            shreg;       // Tx out at [7], rx in at [0]
   logic             miso_bit;    // Held from rising sck
   logic             half_end;

   assign half_end    = (half_cnt == CNT_W'(`SPI_HALF - 1));
   assign spi_busy    = (state != SPI_IDLE);
   assign spi_mosi    = shreg[7];
   assign spi_rx_byte = shreg;    // Complete once done pulses

   ////////////////////
   // Exchange sequencer
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= SPI_IDLE;
         half_cnt <= '0;
         bit_cnt  <= '0;
         spi_sck  <= 1'b0;
         spi_cs_n <= 1'b1;
         spi_done <= 1'b0;
      end else begin
         spi_done <= 1'b0;
         if (state == SPI_IDLE || half_end)
            half_cnt <= '0;
         else
            half_cnt <= half_cnt + 1'b1;

         case (state)
            SPI_IDLE: begin
               if (spi_start) begin
                  state    <= SPI_LEAD;
                  spi_cs_n <= 1'b0;
               end
            end
            SPI_LEAD: begin
               if (half_end) begin
                  state   <= SPI_SHIFT;
                  bit_cnt <= '0;
               end
            end
            SPI_SHIFT: begin
               if (half_end) begin
                  spi_sck <= ~spi_sck;
                  if (spi_sck) begin             // End of high half
                     if (bit_cnt == 3'd7)
                        state <= SPI_TRAIL;
                     else
                        bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            SPI_TRAIL: begin
               if (half_end) begin
                  state    <= SPI_IDLE;
                  spi_cs_n <= 1'b1;
                  spi_done <= 1'b1;
               end
            end
         endcase
      end
   end

   // Shift path
   always_ff @(posedge clk) begin
      if (spi_start)
         shreg <= spi_tx_byte;
      else if (state == SPI_SHIFT && half_end) begin
         if (!spi_sck)
            miso_bit <= spi_miso;                // Rising sck
         else
            shreg <= {shreg[6:0], miso_bit};     // Falling sck
      end
   end

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/100ps
`include "soc_defs.svh"

module uart_rx import soc_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  uart_rxd,    // Asynchronous line
   output logic  rx_done,     // One cycle per good frame
   output byte_t rx_byte
);

   localparam int BAUD_W = $clog2(`UART_DIV);

   uart_state_e       state;
   logic [BAUD_W-1:0] baud_cnt;
   logic [2:0]        bit_cnt;
   byte_t             shreg;
   logic              rxd_s1;     // Synchronizer stage 1
   logic              rxd_s2;     // Synchronizer stage 2
   logic              rxd_d;      // Previous synced value
   logic              half_pt;
   logic              full_pt;
   logic              tick;       // Sample point of current bit

   assign half_pt = (baud_cnt == BAUD_W'(`UART_DIV / 2 - 1));
   assign full_pt = (baud_cnt == BAUD_W'(`UART_DIV - 1));
   // Start bit checked at its middle, later bits one period apart
   assign tick    = (state == UART_START) ? half_pt : full_pt;

   ////////////////////
   // Line synchronizer
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_s1 <= 1'b1;
         rxd_s2 <= 1'b1;
         rxd_d  <= 1'b1;
      end else begin
         rxd_s1 <= uart_rxd;
         rxd_s2 <= rxd_s1;
         rxd_d  <= rxd_s2;                   // For edge detect
      end
   end

   // Receive sequencer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= UART_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         rx_done  <= 1'b0;
      end else begin
         rx_done <= 1'b0;
         if (state == UART_IDLE || tick)
            baud_cnt <= '0;
         else
            baud_cnt <= baud_cnt + 1'b1;

         case (state)
            UART_IDLE: begin
               if (rxd_d && !rxd_s2)
                  state <= UART_START;       // Falling edge seen
            end
            UART_START: begin
               if (tick) begin
                  if (!rxd_s2) begin
                     state   <= UART_DATA;
                     bit_cnt <= '0;
                  end else begin
                     state <= UART_IDLE;     // Glitch, not a start bit
                  end
               end
            end
            UART_DATA: begin
               if (tick) begin
                  if (bit_cnt == 3'd7)
                     state <= UART_STOP;
                  else
                     bit_cnt <= bit_cnt + 1'b1;
               end
            end
            UART_STOP: begin
               if (tick) begin
                  state   <= UART_IDLE;
                  rx_done <= rxd_s2;         // Framing error drops byte
               end
            end
         endcase
      end
   end

   // Data capture
   always_ff @(posedge clk) begin
      if (state == UART_DATA && tick)
         shreg <= {rxd_s2, shreg[7:1]};      // LSB arrives first
      if (state == UART_STOP && tick && rxd_s2)
         rx_byte <= shreg;
   end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/100ps
`include "soc_defs.svh"

module uart_tx import soc_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  tx_start,    // Single-cycle pulse
   input  byte_t tx_byte,
   output logic  tx_busy,
   output logic  uart_txd     // Idles high
);

   localparam int BAUD_W = $clog2(`UART_DIV);

   uart_state_e       state;
   logic [BAUD_W-1:0] baud_cnt;   // Cycles within current bit
   logic [2:0]        bit_cnt;    // Data bit index
   byte_t             shreg;      // Outgoing bits, LSB at [0]
   logic              bit_end;
   logic              shift_en;

   assign bit_end  = (baud_cnt == BAUD_W'(`UART_DIV - 1));
   assign shift_en = bit_end && (state == UART_START || state == UART_DATA);
   assign tx_busy  = (state != UART_IDLE);

   ////////////////////
   // Frame sequencer
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= UART_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         uart_txd <= 1'b1;
      end else begin
         if (state == UART_IDLE || bit_end)
            baud_cnt <= '0;
         else
            baud_cnt <= baud_cnt + 1'b1;

         case (state)
            UART_IDLE: begin
               if (tx_start) begin
                  state    <= UART_START;
                  uart_txd <= 1'b0;          // Start bit next cycle
               end
            end
            UART_START: begin
               if (bit_end) begin
                  state    <= UART_DATA;
                  bit_cnt  <= '0;
                  uart_txd <= shreg[0];      // First data bit
               end
            end
            UART_DATA: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd7) begin
                     state    <= UART_STOP;
                     uart_txd <= 1'b1;       // Stop bit
                  end else begin
                     bit_cnt  <= bit_cnt + 1'b1;
                     uart_txd <= shreg[0];
                  end
               end
            end
            UART_STOP: begin
               if (bit_end)
                  state <= UART_IDLE;        // Line stays high
            end
         endcase
      end
   end

   // Data shift register
   always_ff @(posedge clk) begin
      if (tx_start)
         shreg <= tx_byte;
      else if (shift_en)
         shreg <= {1'b0, shreg[7:1]};        // Next bit into [0]
   end

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

   // Widths with a meaning
   typedef logic [7:0] byte_t;       // Serial data byte
   typedef logic [1:0] reg_addr_t;   // Register address
   typedef logic [7:0] reg_data_t;   // Register data word

   // Shared by the UART transmitter and receiver
   typedef enum logic [1:0] {
      UART_IDLE  = 2'd0,
      UART_START = 2'd1,
      UART_DATA  = 2'd2,
      UART_STOP  = 2'd3
   } uart_state_e;

   // SPI master sequencing
   typedef enum logic [1:0] {
      SPI_IDLE  = 2'd0,   // CS high
      SPI_LEAD  = 2'd1,   // CS low before first clock
      SPI_SHIFT = 2'd2,   // Eight sck periods
      SPI_TRAIL = 2'd3    // Hold after last falling edge
   } spi_state_e;

endpackage

/* rtl/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

////////////////////
// Clock dividers
////////////////////

`define UART_DIV 16          // Clocks per UART bit
`define SPI_HALF 2           // Clocks per SPI half period

////////////////////
// Register map
////////////////////

`define REG_UART_DATA 2'd0   // Tx on write, rx byte on read
`define REG_STATUS    2'd1   // Read only
`define REG_SPI_DATA  2'd2   // Exchange on write, last rx on read

// Status register bit positions
`define ST_TX_BUSY    0
`define ST_RX_VALID   1
`define ST_SPI_BUSY   2
`define ST_RX_OVERRUN 3

`endif
